// File: verilog/fpu_misc_pkg.sv
`default_nettype none

package fpu_misc_pkg;

	localparam int xlen = 64;	// FP registers are always 64 bits wide

	// single precision values live NaN-boxed in the upper half
	localparam logic [31:0] nan_box_s = 32'hffff_ffff;
	localparam logic [xlen-1:0] canon_nan_s = 64'hffff_ffff_7fc0_0000;
	localparam logic [xlen-1:0] canon_nan_d = 64'h7ff8_0000_0000_0000;

	// flag field is {NV, DZ, OF, UF, NX}
	localparam int exc_nv = 4;

	// size field of control[6:5], half (2) is not supported
	localparam logic [1:0] sz_s = 2'd0;
	localparam logic [1:0] sz_d = 2'd1;

	// mode encodings, immed[13:12]
	localparam logic [1:0] sgn_j = 2'd0;
	localparam logic [1:0] sgn_jn = 2'd1;
	localparam logic [1:0] sgn_jx = 2'd2;
	localparam logic [1:0] cmp_le = 2'd0;
	localparam logic [1:0] cmp_lt = 2'd1;
	localparam logic [1:0] cmp_eq = 2'd2;

	typedef enum logic {
		fmt_s = 1'b0,
		fmt_d = 1'b1
	} fp_fmt_e;

	// same numbering as the full FPU op field
	typedef enum logic [3:0] {
		op_fsgn = 4'd5,
		op_fminmax = 4'd6,
		op_fcmp = 4'd12,
		op_fclass = 4'd13,
		op_fmv = 4'd14
	} fpu_op_e;

	typedef struct packed {
		logic valid;
		fpu_op_e op;
		fp_fmt_e fmt;
		logic [1:0] mode;	// sub-operation select
		logic to_float;		// fmv direction, 1 = int -> fp
		logic [4:0] rd;
	} fpu_req_t;

	typedef struct packed {
		logic [xlen-1:0] fa;
		logic [xlen-1:0] fb;
		logic [xlen-1:0] ia;
	} fpu_operands_t;

	// one operand widened to the double layout
	typedef struct packed {
		logic sign;
		logic [10:0] exp;
		logic [51:0] man;
		logic is_nan;
		logic is_snan;
		logic is_inf;
		logic is_zero;
		logic is_sub;
		logic boxed_ok;
	} fp_unpacked_t;

	typedef struct packed {
		logic [xlen-1:0] value;
		logic to_fp;
		logic [4:0] exc;
	} fpu_unit_res_t;

	typedef struct packed {
		logic write;
		logic [4:0] rd;
		logic to_fp;
		logic [xlen-1:0] value;
		logic [4:0] exc;
	} fpu_resp_t;

endpackage

`default_nettype wire

// File: verilog/fpu_issue_reg.sv
`timescale 1ns/1ns
`default_nettype none

module fpu_issue_reg (
	input  logic clk,
	input  logic rst_n,
	input  logic enable,
	input  logic [6:0] control,
	input  logic [4:0] immed,	// instruction bits 16:12
	input  logic [4:0] rd,
	input  logic [fpu_misc_pkg::xlen-1:0] fr1,
	input  logic [fpu_misc_pkg::xlen-1:0] fr2,
	input  logic [fpu_misc_pkg::xlen-1:0] ir1,
	output fpu_misc_pkg::fpu_req_t req,
	output fpu_misc_pkg::fpu_operands_t opnd
);

	logic op_ok;
	logic size_ok;
	fpu_misc_pkg::fpu_req_t req_d;

	// only the single-cycle op codes are accepted here
	always_comb begin
		case (control[3:0])
			fpu_misc_pkg::op_fsgn,
			fpu_misc_pkg::op_fminmax,
			fpu_misc_pkg::op_fcmp,
			fpu_misc_pkg::op_fclass,
			fpu_misc_pkg::op_fmv: op_ok = 1'b1;
			default: op_ok = 1'b0;
		endcase
	end

	assign size_ok = control[6:5] == fpu_misc_pkg::sz_s || control[6:5] == fpu_misc_pkg::sz_d;

	always_comb begin
		req_d.valid = enable & ~control[4] & size_ok & op_ok;	// no fused ops, no half
		req_d.op = fpu_misc_pkg::fpu_op_e'(control[3:0]);
		req_d.fmt = (control[6:5] == fpu_misc_pkg::sz_d) ? fpu_misc_pkg::fmt_d
			: fpu_misc_pkg::fmt_s;
		req_d.mode = immed[1:0];
		req_d.to_float = immed[3];	// xtra
		req_d.rd = rd;
	end

	always_ff @(posedge clk) begin
		req <= req_d;
		opnd <= '{fa: fr1, fb: fr2, ia: ir1};
		if (!rst_n)
			req.valid <= 1'b0;
	end

	a_valid_op: assert property (@(posedge clk) disable iff (!rst_n)
		req.valid |-> req.op inside {fpu_misc_pkg::op_fsgn, fpu_misc_pkg::op_fminmax,
			fpu_misc_pkg::op_fcmp, fpu_misc_pkg::op_fclass, fpu_misc_pkg::op_fmv})
		else $error("issue register holds a valid request with op %0d", req.op);

endmodule

`default_nettype wire

// File: verilog/fp_operand_unpack.sv
`timescale 1ns/1ns
`default_nettype none

module fp_operand_unpack (
	input  fpu_misc_pkg::fp_fmt_e fmt,
	input  logic [fpu_misc_pkg::xlen-1:0] value,
	output fpu_misc_pkg::fp_unpacked_t unp
);

	logic exp_ones;	// raw exponent all ones
	logic exp_zero;	// raw exponent all zeros
	logic man_zero;

	always_comb begin
		unp = '0;
		if (fmt == fpu_misc_pkg::fmt_d) begin
			unp.boxed_ok = 1'b1;
			unp.sign = value[63];
			unp.exp = value[62:52];
			unp.man = value[51:0];
			exp_ones = &value[62:52];
			exp_zero = ~|value[62:52];
		end else begin
			unp.boxed_ok = value[63:32] == fpu_misc_pkg::nan_box_s;
			unp.sign = value[31];
			// rebias 8 -> 11 bits, keeps the order of all encodings
			unp.exp = {value[30], {3{~value[30]}}, value[29:23]};
			unp.man = {value[22:0], 29'b0};	// left aligned
			exp_ones = &value[30:23];
			exp_zero = ~|value[30:23];
		end

		man_zero = unp.man == '0;

		if (unp.boxed_ok) begin
			unp.is_nan = exp_ones & ~man_zero;
			unp.is_snan = exp_ones & ~man_zero & ~unp.man[51];	// quiet bit clear
			unp.is_inf = exp_ones & man_zero;
			unp.is_zero = exp_zero & man_zero;
			unp.is_sub = exp_zero & ~man_zero;
		end else begin
			// bad box reads as the canonical quiet NaN
			unp.is_nan = 1'b1;
			unp.is_snan = 1'b0;
			unp.is_inf = 1'b0;
			unp.is_zero = 1'b0;
			unp.is_sub = 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: verilog/fp_compare_unit.sv
`timescale 1ns/1ns
`default_nettype none

module fp_compare_unit (
	input  fpu_misc_pkg::fpu_req_t req,
	input  fpu_misc_pkg::fp_unpacked_t a,
	input  fpu_misc_pkg::fp_unpacked_t b,
	input  logic [fpu_misc_pkg::xlen-1:0] fa,
	input  logic [fpu_misc_pkg::xlen-1:0] fb,
	output fpu_misc_pkg::fpu_unit_res_t res
);

	logic lt;
	logic eq;
	logic any_nan;
	logic any_snan;
	logic cmp_bit;
	logic pick_a;	// a is the min (or max when inverted)
	logic sel_fa;
	logic sel_fb;
	logic sel_nan;
	logic [fpu_misc_pkg::xlen-1:0] canon;

	assign any_nan = a.is_nan | b.is_nan;
	assign any_snan = a.is_snan | b.is_snan;

	// magnitude/sign ordering, only meaningful without NaNs
	always_comb begin
		eq = 1'b0;
		lt = 1'b0;
		if (a.sign != b.sign) begin
			eq = a.is_zero & b.is_zero;	// -0 == +0
			lt = a.sign & ~eq;
		end else if (a.is_inf | b.is_inf) begin
			eq = a.is_inf & b.is_inf;
			lt = ~eq & ~(a.is_inf ^ a.sign);
		end else if (a.exp != b.exp) begin
			lt = (a.exp < b.exp) ^ a.sign;	// negative values order backwards
		end else if (a.man != b.man) begin
			lt = (a.man < b.man) ^ a.sign;
		end else begin
			eq = 1'b1;
		end
	end

	always_comb begin
		case (req.mode)
			fpu_misc_pkg::cmp_le: cmp_bit = eq | lt;
			fpu_misc_pkg::cmp_lt: cmp_bit = lt;
			fpu_misc_pkg::cmp_eq: cmp_bit = eq;
			default: cmp_bit = 1'b0;
		endcase
		if (any_nan)
			cmp_bit = 1'b0;	// unordered
	end

	// equal values pick by sign so min(-0,+0) is -0
	assign pick_a = (eq ? a.sign : lt) ^ req.mode[0];
	assign sel_nan = a.is_nan & b.is_nan;
	assign sel_fa = (b.is_nan & ~a.is_nan) | (~any_nan & pick_a);
	assign sel_fb = (a.is_nan & ~b.is_nan) | (~any_nan & ~pick_a);
	assign canon = (req.fmt == fpu_misc_pkg::fmt_d) ? fpu_misc_pkg::canon_nan_d
		: fpu_misc_pkg::canon_nan_s;

	always_comb begin
		res.exc = '0;
		if (req.op == fpu_misc_pkg::op_fcmp) begin
			res.value = {{(fpu_misc_pkg::xlen-1){1'b0}}, cmp_bit};
			res.to_fp = 1'b0;
			// le/lt signal on quiet NaNs too, eq only on signalling
			res.exc[fpu_misc_pkg::exc_nv] = any_snan | (any_nan & (req.mode != fpu_misc_pkg::cmp_eq));
		end else begin
			res.value = ({fpu_misc_pkg::xlen{sel_fa}} & fa)
				| ({fpu_misc_pkg::xlen{sel_fb}} & fb)
				| ({fpu_misc_pkg::xlen{sel_nan}} & canon);	// and-or mux
			res.to_fp = 1'b1;
			res.exc[fpu_misc_pkg::exc_nv] = any_snan;
		end
	end

	always_comb begin
		if (req.valid && req.op == fpu_misc_pkg::op_fminmax)
			a_sel_onehot: assert final ($onehot({sel_fa, sel_fb, sel_nan}))
			else $error("min/max selects %b", {sel_fa, sel_fb, sel_nan});
	end

endmodule

`default_nettype wire

// File: verilog/fp_sign_class_unit.sv
`timescale 1ns/1ns
`default_nettype none

module fp_sign_class_unit (
	input  fpu_misc_pkg::fpu_req_t req,
	input  fpu_misc_pkg::fp_unpacked_t a,
	input  logic [fpu_misc_pkg::xlen-1:0] fa,
	input  logic [fpu_misc_pkg::xlen-1:0] fb,
	input  logic [fpu_misc_pkg::xlen-1:0] ia,
	output fpu_misc_pkg::fpu_unit_res_t res
);

	logic is_d;
	logic sign_b;
	logic new_sign;
	logic is_norm;
	logic [9:0] cls;

	assign is_d = req.fmt == fpu_misc_pkg::fmt_d;
	assign sign_b = is_d ? fb[63] : fb[31];

	always_comb begin
		case (req.mode)
			fpu_misc_pkg::sgn_j: new_sign = sign_b;
			fpu_misc_pkg::sgn_jn: new_sign = ~sign_b;
			fpu_misc_pkg::sgn_jx: new_sign = a.sign ^ sign_b;
			default: new_sign = sign_b;
		endcase
	end

	assign is_norm = ~(a.is_nan | a.is_inf | a.is_zero | a.is_sub);

	// fclass, exactly one bit per operand
	always_comb begin
		cls[0] = a.sign & a.is_inf;
		cls[1] = a.sign & is_norm;
		cls[2] = a.sign & a.is_sub;
		cls[3] = a.sign & a.is_zero;
		cls[4] = ~a.sign & a.is_zero;
		cls[5] = ~a.sign & a.is_sub;
		cls[6] = ~a.sign & is_norm;
		cls[7] = ~a.sign & a.is_inf;
		cls[8] = a.is_snan;
		cls[9] = a.is_nan & ~a.is_snan;
	end

	always_comb begin
		res.exc = '0;	// nothing here can raise a flag
		res.to_fp = 1'b1;
		case (req.op)
			fpu_misc_pkg::op_fsgn:
				if (is_d)
					res.value = {new_sign, fa[62:0]};
				else
					res.value = {fpu_misc_pkg::nan_box_s, new_sign, fa[30:0]};
			fpu_misc_pkg::op_fclass: begin
				res.value = {{(fpu_misc_pkg::xlen-10){1'b0}}, cls};
				res.to_fp = 1'b0;
			end
			fpu_misc_pkg::op_fmv:
				if (req.to_float) begin	// fmv.w.x / fmv.d.x
					res.value = is_d ? ia : {fpu_misc_pkg::nan_box_s, ia[31:0]};
				end else begin		// fmv.x.w / fmv.x.d
					res.value = is_d ? fa : {{32{fa[31]}}, fa[31:0]};
					res.to_fp = 1'b0;
				end
			default: begin
				res.value = '0;
				res.to_fp = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: verilog/fpu_result_stage.sv
`timescale 1ns/1ns
`default_nettype none

module fpu_result_stage (
	input  logic clk,
	input  logic rst_n,
	input  fpu_misc_pkg::fpu_req_t req,
	input  fpu_misc_pkg::fpu_unit_res_t cmp_res,
	input  fpu_misc_pkg::fpu_unit_res_t sc_res,
	output fpu_misc_pkg::fpu_resp_t resp
);

	logic use_cmp;
	fpu_misc_pkg::fpu_unit_res_t sel;

	// compare unit owns fmin/fmax and fcmp
	assign use_cmp = req.op == fpu_misc_pkg::op_fminmax || req.op == fpu_misc_pkg::op_fcmp;
	assign sel = use_cmp ? cmp_res : sc_res;

	always_ff @(posedge clk) begin
		resp.write <= req.valid;
		resp.rd <= req.rd;
		resp.to_fp <= req.valid & sel.to_fp;
		resp.value <= sel.value;
		resp.exc <= req.valid ? sel.exc : 5'b0;	// no stray flags on idle cycles
		if (!rst_n) begin
			resp.write <= 1'b0;
			resp.to_fp <= 1'b0;
		end
	end

	a_fp_needs_write: assert property (@(posedge clk) disable iff (!rst_n)
		resp.to_fp |-> resp.write)
		else $error("FP write-back flagged without a completing request");

endmodule

`default_nettype wire

// File: verilog/fpu_misc_top.sv
`timescale 1ns/1ns
`default_nettype none

module fpu_misc_top (
	input  logic clk,
	input  logic rst_n,
	input  logic enable,
	input  logic [6:0] control,	// size, multiple, op
	input  logic [4:0] immed,
	input  logic [4:0] rd,
	input  logic [fpu_misc_pkg::xlen-1:0] fr1,
	input  logic [fpu_misc_pkg::xlen-1:0] fr2,
	input  logic [fpu_misc_pkg::xlen-1:0] ir1,
	output logic [fpu_misc_pkg::xlen-1:0] result,
	output logic [4:0] res_rd,
	output logic res_makes_rd,
	output logic res_makes_fp,
	output logic [4:0] res_exceptions
);

	fpu_misc_pkg::fpu_req_t req;
	fpu_misc_pkg::fpu_operands_t opnd;
	fpu_misc_pkg::fp_unpacked_t unp_a;
	fpu_misc_pkg::fp_unpacked_t unp_b;
	fpu_misc_pkg::fpu_unit_res_t cmp_res;
	fpu_misc_pkg::fpu_unit_res_t sc_res;
	fpu_misc_pkg::fpu_resp_t resp;

	fpu_issue_reg u_issue (
		.clk(clk), .rst_n(rst_n),
		.enable(enable), .control(control), .immed(immed), .rd(rd),
		.fr1(fr1), .fr2(fr2), .ir1(ir1),
		.req(req), .opnd(opnd)
	);

	// one unpacker per fp source
	fp_operand_unpack u_unpack_a (.fmt(req.fmt), .value(opnd.fa), .unp(unp_a));
	fp_operand_unpack u_unpack_b (.fmt(req.fmt), .value(opnd.fb), .unp(unp_b));

	fp_compare_unit u_cmp (
		.req(req), .a(unp_a), .b(unp_b),
		.fa(opnd.fa), .fb(opnd.fb),
		.res(cmp_res)
	);

	fp_sign_class_unit u_sign_class (
		.req(req), .a(unp_a),
		.fa(opnd.fa), .fb(opnd.fb), .ia(opnd.ia),
		.res(sc_res)
	);

	fpu_result_stage u_result (
		.clk(clk), .rst_n(rst_n),
		.req(req), .cmp_res(cmp_res), .sc_res(sc_res),
		.resp(resp)
	);

	assign result = resp.value;
	assign res_rd = resp.rd;
	assign res_makes_rd = resp.write;
	assign res_makes_fp = resp.to_fp;
	assign res_exceptions = resp.exc;

endmodule

`default_nettype wire

// File: bench/fpu_misc_tb.sv
`timescale 1ns/1ns
`default_nettype none

module fpu_misc_tb;

	localparam int n_req = 2000;
	localparam int timeout_ns = (n_req + 20) * 10;

	typedef enum logic [2:0] {
		k_idle,
		k_illegal,
		k_fsgn,
		k_fminmax,
		k_fcmp,
		k_fclass,
		k_fmv
	} check_kind_e;

	typedef struct packed {
		check_kind_e kind;
		fpu_misc_pkg::fpu_resp_t resp;
	} expect_t;

	logic clk = 1'b0;
	logic rst_n;
	logic enable;
	logic [6:0] control;
	logic [4:0] immed;
	logic [4:0] rd;
	logic [63:0] fr1;
	logic [63:0] fr2;
	logic [63:0] ir1;
	logic [63:0] result;
	logic [4:0] res_rd;
	logic res_makes_rd;
	logic res_makes_fp;
	logic [4:0] res_exceptions;

	logic [31:0] seed;
	int errors;
	int issued;
	int valid_cnt;
	logic checking;	// response checks armed
	expect_t due;	// response expected in this cycle
	expect_t expected[$];

	fpu_misc_top uut (
		.clk(clk), .rst_n(rst_n),
		.enable(enable), .control(control), .immed(immed), .rd(rd),
		.fr1(fr1), .fr2(fr2), .ir1(ir1),
		.result(result), .res_rd(res_rd), .res_makes_rd(res_makes_rd),
		.res_makes_fp(res_makes_fp), .res_exceptions(res_exceptions)
	);

	always #5 clk = ~clk;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] rand32();
		seed = xorshift(seed);
		return seed;
	endfunction

	function automatic string test_name(input check_kind_e k);
		case (k)
			k_illegal: return "illegal";
			k_fsgn: return "fsgn";
			k_fminmax: return "fminmax";
			k_fcmp: return "fcmp";
			k_fclass: return "fclass";
			k_fmv: return "fmv";
			default: return "idle";
		endcase
	endfunction

	task automatic report_value(input string test, input string field,
			input logic [63:0] expv, input logic [63:0] actv);
		errors++;
		$display("[ERROR] %s: %s expected %h, actual %h at %0t", test, field, expv, actv, $time);
	endtask

	// special operands, boxed S values plus one broken box
	function automatic logic [63:0] special_s(input int idx);
		case (idx)
			0: return 64'hffff_ffff_0000_0000;
			1: return 64'hffff_ffff_8000_0000;
			2: return 64'hffff_ffff_7f80_0000;
			3: return 64'hffff_ffff_ff80_0000;
			4: return 64'hffff_ffff_7fc0_0000;
			5: return 64'hffff_ffff_7fa0_0000;	// signalling
			6: return 64'hffff_ffff_0000_0001;
			7: return 64'hffff_ffff_807f_ffff;
			8: return 64'hffff_ffff_3f80_0000;
			9: return 64'hffff_ffff_bf80_0000;
			default: return 64'h0000_0000_3f80_0000;
		endcase
	endfunction

	function automatic logic [63:0] special_d(input int idx);
		case (idx)
			0: return 64'h0000_0000_0000_0000;
			1: return 64'h8000_0000_0000_0000;
			2: return 64'h7ff0_0000_0000_0000;
			3: return 64'hfff0_0000_0000_0000;
			4: return 64'h7ff8_0000_0000_0000;
			5: return 64'h7ff4_0000_0000_0000;	// signalling
			6: return 64'h0000_0000_0000_0001;
			7: return 64'h800f_ffff_ffff_ffff;
			8: return 64'h3ff0_0000_0000_0000;
			default: return 64'hbff0_0000_0000_0000;
		endcase
	endfunction

	function automatic logic [63:0] pick_operand(input logic is_d);
		logic [31:0] r;
		r = rand32();
		if (r[1] == 1'b0)
			return is_d ? special_d(int'(rand32() % 10)) : special_s(int'(rand32() % 11));
		return is_d ? {rand32(), rand32()} : {32'hffff_ffff, rand32()};
	endfunction

	function automatic logic sign_of(input logic is_d, input logic [63:0] v);
		return is_d ? v[63] : v[31];
	endfunction

	function automatic logic [62:0] mag_of(input logic is_d, input logic [63:0] v);
		return is_d ? v[62:0] : {32'b0, v[30:0]};
	endfunction

	// class bit of one operand, bad S box reads as quiet NaN
	function automatic logic [9:0] class_of(input logic is_d, input logic [63:0] v);
		logic s;
		logic exp_max;
		logic exp_zero;
		logic frac_zero;
		logic quiet;
		logic [9:0] c;
		c = '0;
		if (!is_d && v[63:32] != 32'hffff_ffff) begin
			c[9] = 1'b1;
			return c;
		end
		s = sign_of(is_d, v);
		exp_max = is_d ? &v[62:52] : &v[30:23];
		exp_zero = is_d ? ~|v[62:52] : ~|v[30:23];
		frac_zero = is_d ? ~|v[51:0] : ~|v[22:0];
		quiet = is_d ? v[51] : v[22];
		if (exp_max && !frac_zero)
			c[quiet ? 9 : 8] = 1'b1;
		else if (exp_max)
			c[s ? 0 : 7] = 1'b1;
		else if (exp_zero && frac_zero)
			c[s ? 3 : 4] = 1'b1;
		else if (exp_zero)
			c[s ? 2 : 5] = 1'b1;
		else
			c[s ? 1 : 6] = 1'b1;
		return c;
	endfunction

	// ordering of two non-NaN values
	function automatic logic less_than(input logic is_d, input logic [63:0] a, input logic [63:0] b);
		logic sa;
		logic sb;
		logic [62:0] ma;
		logic [62:0] mb;
		sa = sign_of(is_d, a);
		sb = sign_of(is_d, b);
		ma = mag_of(is_d, a);
		mb = mag_of(is_d, b);
		if (ma == '0 && mb == '0)
			return 1'b0;
		if (sa != sb)
			return sa;
		return sa ? (ma > mb) : (ma < mb);
	endfunction

	function automatic logic equal_to(input logic is_d, input logic [63:0] a, input logic [63:0] b);
		logic [62:0] ma;
		logic [62:0] mb;
		ma = mag_of(is_d, a);
		mb = mag_of(is_d, b);
		return (ma == '0 && mb == '0) || (sign_of(is_d, a) == sign_of(is_d, b) && ma == mb);
	endfunction

	// reference model of one request
	function automatic expect_t model(input logic en, input logic [6:0] ctl, input logic [4:0] imm,
			input logic [4:0] rd_in, input logic [63:0] a, input logic [63:0] b,
			input logic [63:0] i);
		expect_t e;
		logic is_d;
		logic [1:0] mode;
		logic [9:0] cls_a;
		logic [9:0] cls_b;
		logic nan_a;
		logic nan_b;
		logic any_snan;
		logic lt;
		logic gt;
		logic eq;
		logic sa;
		logic sb;
		logic ns;
		e = '0;
		e.kind = k_idle;
		if (!en)
			return e;
		e.kind = k_illegal;
		if (ctl[4] || ctl[6:5] > 2'd1)
			return e;
		is_d = ctl[6:5] == 2'd1;
		mode = imm[1:0];
		cls_a = class_of(is_d, a);
		cls_b = class_of(is_d, b);
		nan_a = |cls_a[9:8];
		nan_b = |cls_b[9:8];
		any_snan = cls_a[8] | cls_b[8];
		lt = less_than(is_d, a, b);
		gt = less_than(is_d, b, a);
		eq = equal_to(is_d, a, b);
		sa = sign_of(is_d, a);
		sb = sign_of(is_d, b);
		e.resp.write = 1'b1;
		e.resp.rd = rd_in;
		case (ctl[3:0])
			fpu_misc_pkg::op_fsgn: begin
				e.kind = k_fsgn;
				ns = (mode == 2'd0) ? sb : (mode == 2'd1) ? ~sb : sa ^ sb;
				e.resp.value = is_d ? {ns, a[62:0]} : {32'hffff_ffff, ns, a[30:0]};
				e.resp.to_fp = 1'b1;
			end
			fpu_misc_pkg::op_fminmax: begin
				e.kind = k_fminmax;
				e.resp.to_fp = 1'b1;
				e.resp.exc[4] = any_snan;
				if (nan_a && nan_b)
					e.resp.value = is_d ? fpu_misc_pkg::canon_nan_d : fpu_misc_pkg::canon_nan_s;
				else if (nan_a)
					e.resp.value = b;
				else if (nan_b)
					e.resp.value = a;
				else if (mode[0])	// max, +0 wins over -0
					e.resp.value = (gt || (eq && !sa)) ? a : b;
				else
					e.resp.value = (lt || (eq && sa)) ? a : b;
			end
			fpu_misc_pkg::op_fcmp: begin
				e.kind = k_fcmp;
				if (!(nan_a || nan_b))
					e.resp.value[0] = (mode == 2'd0) ? (lt | eq) : (mode == 2'd1) ? lt : eq;
				e.resp.exc[4] = any_snan | ((nan_a | nan_b) & (mode != 2'd2));
			end
			fpu_misc_pkg::op_fclass: begin
				e.kind = k_fclass;
				e.resp.value = {54'b0, cls_a};
			end
			fpu_misc_pkg::op_fmv: begin
				e.kind = k_fmv;
				e.resp.to_fp = imm[3];
				if (imm[3])
					e.resp.value = is_d ? i : {32'hffff_ffff, i[31:0]};
				else
					e.resp.value = is_d ? a : {{32{a[31]}}, a[31:0]};
			end
			default: begin
				e.resp.write = 1'b0;
				e.kind = k_illegal;
			end
		endcase
		return e;
	endfunction

	task automatic drive_random();
		logic [31:0] r;
		logic [3:0] op;
		logic [1:0] size;
		logic multiple;
		expect_t e;
		r = rand32();
		case (rand32() % 5)
			0: op = fpu_misc_pkg::op_fsgn;
			1: op = fpu_misc_pkg::op_fminmax;
			2: op = fpu_misc_pkg::op_fcmp;
			3: op = fpu_misc_pkg::op_fclass;
			default: op = fpu_misc_pkg::op_fmv;
		endcase
		size = {1'b0, r[4]};
		multiple = 1'b0;
		if (r[9:7] == 3'd0) begin	// about one in eight is rejected
			case (r[11:10])
				2'd0: multiple = 1'b1;
				2'd1: size = 2'd2;	// half
				2'd2: size = 2'd3;
				default: op = 4'd0;
			endcase
		end
		enable = r[3:0] != 4'd0;
		control = {size, multiple, op};
		immed = {r[20], r[21], r[22], 2'(rand32() % 3)};
		rd = r[28:24];
		fr1 = pick_operand(size == 2'd1);
		fr2 = (r[31:29] == 3'd0) ? fr1 : pick_operand(size == 2'd1);
		ir1 = {rand32(), rand32()};
		e = model(enable, control, immed, rd, fr1, fr2, ir1);
		expected.push_back(e);
		issued++;
		if (e.resp.write)
			valid_cnt++;
	endtask

	task automatic drive_idle();
		enable = 1'b0;
		expected.push_back(model(enable, control, immed, rd, fr1, fr2, ir1));
	endtask

	// response checks, sampled at the rising edge after the expectation is set
	a_write: assert property (@(posedge clk) checking |-> res_makes_rd == due.resp.write)
		else report_value(test_name($sampled(due.kind)), "res_makes_rd",
			$sampled(due.resp.write), $sampled(res_makes_rd));
	a_to_fp: assert property (@(posedge clk) checking |-> res_makes_fp == due.resp.to_fp)
		else report_value(test_name($sampled(due.kind)), "res_makes_fp",
			$sampled(due.resp.to_fp), $sampled(res_makes_fp));
	a_rd: assert property (@(posedge clk) checking && due.resp.write |-> res_rd == due.resp.rd)
		else report_value(test_name($sampled(due.kind)), "res_rd",
			$sampled(due.resp.rd), $sampled(res_rd));
	a_value: assert property (@(posedge clk)
		checking && due.resp.write |-> result == due.resp.value)
		else report_value(test_name($sampled(due.kind)), "result",
			$sampled(due.resp.value), $sampled(result));
	a_flags: assert property (@(posedge clk)
		checking && due.resp.write |-> res_exceptions == due.resp.exc)
		else report_value(test_name($sampled(due.kind)), "res_exceptions",
			$sampled(due.resp.exc), $sampled(res_exceptions));
	a_class_onehot: assert property (@(posedge clk)
		checking && due.resp.write && due.kind == k_fclass
		|-> $onehot(result[9:0]) && result[63:10] == '0)
		else report_value("fclass", "one-hot class", $sampled(due.resp.value), $sampled(result));

	initial begin
		seed = 32'hed10a0a8;
		errors = 0;
		issued = 0;
		valid_cnt = 0;
		checking = 1'b0;
		due = '0;
		rst_n = 1'b0;
		enable = 1'b0;
		control = '0;
		immed = '0;
		rd = '0;
		fr1 = '0;
		fr2 = '0;
		ir1 = '0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		// both pipeline stages come out of reset empty
		expected.push_back(model(1'b0, '0, '0, '0, '0, '0, '0));
		expected.push_back(model(1'b0, '0, '0, '0, '0, '0, '0));
		checking = 1'b1;
		for (int k = 0; k < n_req + 2; k++) begin
			due = expected.pop_front();
			if (k < n_req)
				drive_random();
			else
				drive_idle();
			@(negedge clk);
		end
		checking = 1'b0;
		$display("requests %0d, valid %0d, errors %0d", issued, valid_cnt, errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

	initial begin
		#(timeout_ns);
		$display("watchdog expired, run did not finish within %0d ns", timeout_ns);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: files.f
verilog/fpu_misc_pkg.sv
verilog/fpu_issue_reg.sv
verilog/fp_operand_unpack.sv
verilog/fp_compare_unit.sv
verilog/fp_sign_class_unit.sv
verilog/fpu_result_stage.sv
verilog/fpu_misc_top.sv
bench/fpu_misc_tb.sv
